// File: isp_top.f
verilog/axi_read_pkg.sv
verilog/focus_pkg.sv
verilog/dram_reader.sv
verilog/gray_accumulator.sv
verilog/focus_evaluator.sv
verilog/isp_top.sv
verification/axi_dram_model.sv
verification/tb_isp_top.sv

// File: Bender.yml
package:
  name: isp_top

sources:
  - verilog/axi_read_pkg.sv
  - verilog/focus_pkg.sv
  - verilog/dram_reader.sv
  - verilog/gray_accumulator.sv
  - verilog/focus_evaluator.sv
  - verilog/isp_top.sv
  - target: test
    files:
      - verification/axi_dram_model.sv
      - verification/tb_isp_top.sv

// File: verification/tb_isp_top.sv
module tb_isp_top;

    localparam int n_entries      = 9;
    localparam int timeout_cycles = 4000;
    localparam int row_bytes      = 32;
    // centred crop starts at this row and column
    localparam int crop_first     = row_bytes / 2 - 3;
    localparam int pat_flat       = 0;
    localparam int pat_check2     = 1;
    localparam int pat_check4     = 2;
    localparam int pat_stripes    = 3;
    localparam int pat_random     = 4;

    logic                            clk;
    logic                            rst_n;
    logic                            in_valid;
    logic [focus_pkg::pic_no_w-1:0]  in_pic_no;
    logic                            out_valid;
    focus_pkg::focus_t               out_data;
    logic [axi_read_pkg::id_w-1:0]   arid;
    logic [axi_read_pkg::addr_w-1:0] araddr;
    logic [7:0]                      arlen;
    logic [2:0]                      arsize;
    logic [1:0]                      arburst;
    logic                            arvalid;
    logic                            arready;
    logic [axi_read_pkg::id_w-1:0]   rid;
    logic [axi_read_pkg::data_w-1:0] rdata;
    logic [1:0]                      rresp;
    logic                            rlast;
    logic                            rvalid;
    logic                            rready;

    // ==================================================
    // stimulus table
    // ==================================================
    int tbl_pic [n_entries] = '{0, 1, 2, 3, 4, 9, 15, 7, 10};
    int tbl_pat [n_entries] = '{pat_flat, pat_check2, pat_stripes, pat_check4,
                                pat_random, pat_random, pat_random, pat_random, pat_random};
    // random rows are filled in by the reference model
    focus_pkg::focus_t tbl_exp [n_entries] = '{focus_pkg::win_2x2, focus_pkg::win_2x2,
        focus_pkg::win_6x6, focus_pkg::win_4x4, focus_pkg::win_2x2, focus_pkg::win_2x2,
        focus_pkg::win_2x2, focus_pkg::win_2x2, focus_pkg::win_2x2};

    int                              val_errs   = 0;
    int                              proto_errs = 0;
    int                              timeouts   = 0;
    int                              pulses     = 0;
    int                              ar_cnt     = 0;
    int                              first_rnd;
    logic [axi_read_pkg::addr_w-1:0] ar_log [4];
    logic                            timed_out;

    initial clk = 1'b0;
    always #20 clk = ~clk;

    isp_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pic_no (in_pic_no),
        .out_valid (out_valid),
        .out_data  (out_data),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .arsize    (arsize),
        .arburst   (arburst),
        .arvalid   (arvalid),
        .arready   (arready),
        .rid       (rid),
        .rdata     (rdata),
        .rresp     (rresp),
        .rlast     (rlast),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    axi_dram_model i_dram (
        .clk     (clk),
        .rst_n   (rst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    // address log and output pulse monitor
    always @(negedge clk) begin
        if (rst_n && arvalid && arready) begin
            if (ar_cnt < 4) begin
                ar_log[ar_cnt] = araddr;
            end
            ar_cnt++;
        end
        if (rst_n && out_valid) begin
            pulses++;
        end
        if (rst_n && !out_valid && out_data != focus_pkg::win_2x2) begin
            val_errs++;
            $display("Fail out_data: got %h expected %h while out_valid low", out_data, 2'h0);
        end
    end

    // distance ring of one crop coordinate, 0 at the centre
    function automatic int ring_of(input int x);
        int d;
        d = 2 * x - 5;
        if (d < 0) begin
            d = -d;
        end
        return (d - 1) / 2;
    endfunction

    function automatic logic [7:0] pattern_byte(input int pat, input int row, input int col);
        int         half;
        logic [7:0] v;
        half = (pat == pat_check4) ? 2 : 1;
        if (pat == pat_flat) begin
            v = 8'd90;
        end else if (pat == pat_stripes) begin
            // edges only between crop columns 0/1 and 4/5
            v = (col <= 13 || col >= 18) ? 8'd200 : 8'd40;
        end else if (row >= 16 - half && row <= 15 + half && col >= 16 - half
                     && col <= 15 + half && (row + col) % 2 == 0) begin
            v = 8'd200;
        end else begin
            v = 8'd40;
        end
        return v;
    endfunction

    task automatic fill_picture(input int pic, input int pat);
        int         base;
        logic [7:0] v;
        for (int p = 0; p < focus_pkg::num_planes; p++) begin
            base = pic * axi_read_pkg::pic_stride + p * axi_read_pkg::plane_stride;
            for (int r = 0; r < axi_read_pkg::plane_stride / row_bytes; r++) begin
                for (int c = 0; c < row_bytes; c++) begin
                    v = (pat == pat_random) ? 8'($urandom) : pattern_byte(pat, r, c);
                    i_dram.mem[base + r * row_bytes + c] = v;
                end
            end
        end
    endtask

    // grey crop and window contrast straight from the memory image
    task automatic reference_focus(input int pic, output focus_pkg::focus_t res);
        int g [6][6];
        int s [3];
        int off;
        int lv;
        int d;
        int t2;
        int t4;
        int t6;
        s = '{0, 0, 0};
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                off = pic * axi_read_pkg::pic_stride
                    + (crop_first + i) * row_bytes + crop_first + j;
                g[i][j] = (int'(i_dram.mem[off])
                         + 2 * int'(i_dram.mem[off + axi_read_pkg::plane_stride])
                         + int'(i_dram.mem[off + 2 * axi_read_pkg::plane_stride])) / 4;
            end
        end
        // a pair counts once for each direction
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 6; j++) begin
                lv = (ring_of(i) > ring_of(j)) ? ring_of(i) : ring_of(j);
                if (j < 5) begin
                    d = (g[i][j] > g[i][j+1]) ? g[i][j] - g[i][j+1] : g[i][j+1] - g[i][j];
                    s[(lv > ring_of(j+1)) ? lv : ring_of(j+1)] += 2 * d;
                end
                if (i < 5) begin
                    d = (g[i][j] > g[i+1][j]) ? g[i][j] - g[i+1][j] : g[i+1][j] - g[i][j];
                    s[(lv > ring_of(i+1)) ? lv : ring_of(i+1)] += 2 * d;
                end
            end
        end
        t2 = s[0] / 4;
        t4 = (s[0] + s[1]) / 16;
        t6 = (s[0] + s[1] + s[2]) / 36;
        if (t2 >= t4 && t2 >= t6) begin
            res = focus_pkg::win_2x2;
        end else if (t4 >= t6) begin
            res = focus_pkg::win_4x4;
        end else begin
            res = focus_pkg::win_6x6;
        end
    endtask

    task automatic send_command(input int pic);
        @(posedge clk);
        #5;
        in_valid  = 1'b1;
        in_pic_no = pic[focus_pkg::pic_no_w-1:0];
        @(posedge clk);
        #5;
        in_valid  = 1'b0;
    endtask

    task automatic wait_result(output logic late);
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        late = !out_valid;
    endtask

    task automatic check_bursts(input int pic);
        logic [axi_read_pkg::addr_w-1:0] exp_addr;
        if (ar_cnt != focus_pkg::num_planes) begin
            proto_errs++;
            $display("picture %0d was read with %0d bursts instead of 3", pic, ar_cnt);
        end
        for (int p = 0; p < focus_pkg::num_planes && p < ar_cnt; p++) begin
            exp_addr = axi_read_pkg::dram_base + pic * axi_read_pkg::pic_stride
                     + p * axi_read_pkg::plane_stride + crop_first * row_bytes;
            if (ar_log[p] != exp_addr) begin
                val_errs++;
                $display("Fail araddr burst %0d: got %h expected %h", p, ar_log[p], exp_addr);
            end
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        first_rnd = $urandom(7);
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pic_no = '0;
        timed_out = 1'b0;
        repeat (16) @(posedge clk);
        #5;
        rst_n = 1'b1;

        for (int k = 0; k < n_entries; k++) begin
            fill_picture(tbl_pic[k], tbl_pat[k]);
            if (tbl_pat[k] == pat_random) begin
                reference_focus(tbl_pic[k], tbl_exp[k]);
            end
            ar_cnt = 0;
            send_command(tbl_pic[k]);
            wait_result(timed_out);
            if (timed_out) begin
                timeouts++;
                $display("no out_valid within %0d cycles for entry %0d", timeout_cycles, k);
                break;
            end
            if (out_data != tbl_exp[k]) begin
                val_errs++;
                $display("Fail out_data entry %0d: got %h expected %h", k, out_data, tbl_exp[k]);
            end
            @(negedge clk);
            if (out_valid) begin
                val_errs++;
                $display("Fail out_valid one cycle after pulse: got %h expected %h", out_valid, 1'b0);
            end
            #5;
            check_bursts(tbl_pic[k]);
            if (pulses != k + 1) begin
                proto_errs++;
                $display("after entry %0d saw %0d out_valid pulses, expected %0d", k, pulses, k + 1);
            end
        end

        proto_errs = proto_errs + i_dram.proto_errs;
        $display("errors: %0d value, %0d protocol, %0d timeout", val_errs, proto_errs, timeouts);
        if (val_errs == 0 && proto_errs == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verification/axi_dram_model.sv
module axi_dram_model (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [axi_read_pkg::id_w-1:0]   arid,
    input  logic [axi_read_pkg::addr_w-1:0] araddr,
    input  logic [7:0]                      arlen,
    input  logic [2:0]                      arsize,
    input  logic [1:0]                      arburst,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [axi_read_pkg::id_w-1:0]   rid,
    output logic [axi_read_pkg::data_w-1:0] rdata,
    output logic [1:0]                      rresp,
    output logic                            rlast,
    output logic                            rvalid,
    input  logic                            rready
);

    // sixteen pictures from dram_base upwards
    localparam int unsigned mem_bytes = 16 * axi_read_pkg::pic_stride;

    logic [7:0]                      mem [mem_bytes];
    int                              proto_errs;
    logic                            ar_fire;
    logic                            r_fire;
    logic                            ar_wait;
    logic [axi_read_pkg::addr_w-1:0] ar_hold;
    logic [axi_read_pkg::id_w-1:0]   id_hold;
    logic                            busy;
    logic [axi_read_pkg::addr_w-1:0] beat_addr;
    int                              beats_left;

    function automatic logic [axi_read_pkg::data_w-1:0] read_beat(
        input logic [axi_read_pkg::addr_w-1:0] addr
    );
        logic [axi_read_pkg::data_w-1:0] data;
        int unsigned                     off;
        data = '0;
        for (int b = 0; b < axi_read_pkg::beat_bytes; b++) begin
            off = addr - axi_read_pkg::dram_base + b;
            if (off < mem_bytes) begin
                data[b*8 +: 8] = mem[off];
            end
        end
        return data;
    endfunction

    // background depends on every address bit
    initial begin
        logic [31:0] a;
        for (int i = 0; i < mem_bytes; i++) begin
            a      = axi_read_pkg::dram_base + i;
            mem[i] = a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24];
        end
        proto_errs = 0;
        ar_wait    = 1'b0;
        busy       = 1'b0;
        beats_left = 0;
        arready    = 1'b0;
        rid        = '0;
        rdata      = '0;
        rresp      = 2'b00;
        rlast      = 1'b0;
        rvalid     = 1'b0;
    end

    // ==================================================
    // protocol checks, sampled mid cycle
    // ==================================================
    always @(negedge clk) begin
        ar_fire = rst_n && arvalid && arready;
        r_fire  = rst_n && rvalid && rready;
        if (rst_n && ar_wait && (!arvalid || araddr != ar_hold)) begin
            proto_errs++;
            $display("read address dropped or changed before arready at %0t", $time);
        end
        ar_wait = rst_n && arvalid && !arready;
        ar_hold = araddr;
        id_hold = arid;
        if (ar_fire && (arid != '0 || arlen != 8'(axi_read_pkg::burst_len - 1)
                || arsize != axi_read_pkg::size_16b || arburst != axi_read_pkg::burst_incr)) begin
            proto_errs++;
            $display("burst at %h does not have the expected id, length, size or type", araddr);
        end
        if (ar_fire && (araddr < axi_read_pkg::dram_base || araddr - axi_read_pkg::dram_base
                + axi_read_pkg::burst_len * axi_read_pkg::beat_bytes > mem_bytes)) begin
            proto_errs++;
            $display("burst at %h falls outside the picture memory", araddr);
        end
    end

    // one burst at a time, random stalls on both channels
    always @(posedge clk) begin
        #5;
        if (!rst_n) begin
            busy    = 1'b0;
            arready = 1'b0;
            rvalid  = 1'b0;
            rlast   = 1'b0;
        end else begin
            if (r_fire) begin
                rvalid     = 1'b0;
                beat_addr  = beat_addr + axi_read_pkg::beat_bytes;
                beats_left = beats_left - 1;
                if (beats_left == 0) begin
                    busy = 1'b0;
                end
            end
            if (ar_fire) begin
                busy       = 1'b1;
                beat_addr  = ar_hold;
                beats_left = axi_read_pkg::burst_len;
                rid        = id_hold;
            end
            arready = !busy && ($urandom % 4 != 0);
            if (busy && !rvalid) begin
                rvalid = ($urandom % 3 != 0);
            end
            rdata = busy ? read_beat(beat_addr) : '0;
            rlast = busy && beats_left == 1;
        end
    end

endmodule

// File: verilog/isp_top.sv
module isp_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [focus_pkg::pic_no_w-1:0]  in_pic_no,
    output logic                            out_valid,
    output focus_pkg::focus_t               out_data,
    output logic [axi_read_pkg::id_w-1:0]   arid,
    output logic [axi_read_pkg::addr_w-1:0] araddr,
    output logic [7:0]                      arlen,
    output logic [2:0]                      arsize,
    output logic [1:0]                      arburst,
    output logic                            arvalid,
    input  logic                            arready,
    input  logic [axi_read_pkg::id_w-1:0]   rid,
    input  logic [axi_read_pkg::data_w-1:0] rdata,
    input  logic [1:0]                      rresp,
    input  logic                            rlast,
    input  logic                            rvalid,
    output logic                            rready
);

    logic             row_valid;
    logic             row_ready;
    focus_pkg::row_t  row_pixels;
    logic [1:0]       row_plane;
    logic             crop_valid;
    logic             crop_ready;
    focus_pkg::crop_t crop_gray;

    // fixed burst shape, one burst per plane
    assign arid    = '0;
    assign arlen   = 8'(axi_read_pkg::burst_len - 1);
    assign arsize  = axi_read_pkg::size_16b;
    assign arburst = axi_read_pkg::burst_incr;

    dram_reader i_reader (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_pic_no  (in_pic_no),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rready     (rready),
        .row_valid  (row_valid),
        .row_pixels (row_pixels),
        .row_plane  (row_plane),
        .row_ready  (row_ready)
    );

    gray_accumulator i_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_valid  (row_valid),
        .row_pixels (row_pixels),
        .row_plane  (row_plane),
        .row_ready  (row_ready),
        .crop_valid (crop_valid),
        .crop_gray  (crop_gray),
        .crop_ready (crop_ready)
    );

    focus_evaluator i_eval (
        .clk        (clk),
        .rst_n      (rst_n),
        .crop_valid (crop_valid),
        .crop_gray  (crop_gray),
        .crop_ready (crop_ready),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

// File: verilog/focus_evaluator.sv
module focus_evaluator (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              crop_valid,
    input  focus_pkg::crop_t  crop_gray,
    output logic              crop_ready,
    output logic              out_valid,
    output focus_pkg::focus_t out_data
);

    focus_pkg::crop_t             crop_q;
    focus_pkg::focus_t            result_q;
    logic                         busy;
    logic                         crop_hs;
    logic [6:0]                   cnt;
    logic [6:0]                   vcnt;
    logic [2:0]                   ra;
    logic [2:0]                   ca;
    logic [2:0]                   rb;
    logic [2:0]                   cb;
    logic [focus_pkg::pix_w-1:0]  pix_a;
    logic [focus_pkg::pix_w-1:0]  pix_b;
    logic [focus_pkg::pix_w-1:0]  diff;
    logic [1:0]                   lvl_a;
    logic [1:0]                   lvl_b;
    logic [1:0]                   win;
    logic [14:0]                  s2;
    logic [14:0]                  s4;
    logic [14:0]                  s6;
    logic [14:0]                  t2;
    logic [14:0]                  t4;
    logic [14:0]                  t6;

    // ring of one coordinate, 0 is the centre pair
    function automatic logic [1:0] coord_lvl(input logic [2:0] x);
        case (x)
            3'd2, 3'd3: coord_lvl = 2'd0;
            3'd1, 3'd4: coord_lvl = 2'd1;
            default:    coord_lvl = 2'd2;
        endcase
    endfunction

    function automatic logic [1:0] pix_lvl(input logic [2:0] r, input logic [2:0] c);
        logic [1:0] lr;
        logic [1:0] lc;
        lr = coord_lvl(r);
        lc = coord_lvl(c);
        return (lr > lc) ? lr : lc;
    endfunction

    assign crop_ready = !busy;
    assign crop_hs    = crop_valid && crop_ready;
    assign vcnt       = cnt - 7'd60;

    // ==================================================
    // pair walk: 60 horizontal, then 60 vertical
    // ==================================================
    always_comb begin
        // each pair is visited twice, once per direction
        if (cnt < 7'd60) begin
            ra = 3'((cnt % 7'd30) / 7'd5);
            ca = 3'(cnt % 7'd5);
            rb = ra;
            cb = ca + 3'd1;
        end else begin
            ra = 3'((vcnt % 7'd30) / 7'd6);
            ca = 3'(vcnt % 7'd6);
            rb = ra + 3'd1;
            cb = ca;
        end
    end

    assign pix_a = crop_q[(ra*focus_pkg::crop_dim + ca)*focus_pkg::pix_w +: focus_pkg::pix_w];
    assign pix_b = crop_q[(rb*focus_pkg::crop_dim + cb)*focus_pkg::pix_w +: focus_pkg::pix_w];
    assign diff  = (pix_a > pix_b) ? pix_a - pix_b : pix_b - pix_a;
    assign lvl_a = pix_lvl(ra, ca);
    assign lvl_b = pix_lvl(rb, cb);
    // smallest window holding both pixels
    assign win   = (lvl_a > lvl_b) ? lvl_a : lvl_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            cnt       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (crop_hs) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 7'd1;
                if (cnt == 7'd121) begin
                    busy      <= 1'b0;
                    out_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (crop_hs) begin
            crop_q <= crop_gray;
            s2     <= '0;
            s4     <= '0;
            s6     <= '0;
        end else if (busy) begin
            if (cnt < 7'd120) begin
                case (win)
                    2'd0:    s2 <= s2 + diff;
                    2'd1:    s4 <= s4 + diff;
                    default: s6 <= s6 + diff;
                endcase
            end else if (cnt == 7'd120) begin
                // normalise by window area
                t2 <= s2 >> 2;
                t4 <= (s2 + s4) >> 4;
                t6 <= (s2 + s4 + s6) / 15'd36;
            end else if (cnt == 7'd121) begin
                // ties go to the smaller window
                if (t2 >= t4 && t2 >= t6) begin
                    result_q <= focus_pkg::win_2x2;
                end else if (t4 >= t6) begin
                    result_q <= focus_pkg::win_4x4;
                end else begin
                    result_q <= focus_pkg::win_6x6;
                end
            end
        end
    end

    assign out_data = out_valid ? result_q : focus_pkg::focus_t'(2'd0);

    a_fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
        crop_hs |-> ##123 out_valid);

endmodule

// File: verilog/gray_accumulator.sv
module gray_accumulator (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             row_valid,
    input  focus_pkg::row_t  row_pixels,
    input  logic [1:0]       row_plane,
    output logic             row_ready,
    output logic             crop_valid,
    output focus_pkg::crop_t crop_gray,
    input  logic             crop_ready
);

    logic [focus_pkg::acc_w-1:0] sum_q [focus_pkg::crop_dim*focus_pkg::crop_dim];
    logic [4:0]                  row_cnt;
    logic [2:0]                  slot;
    logic                        last_row;
    logic                        row_hs;

    function automatic logic [focus_pkg::acc_w-1:0] weigh(
        input logic [focus_pkg::pix_w-1:0] pix,
        input logic [1:0]                  plane
    );
        logic [focus_pkg::acc_w-1:0] ext;
        ext = pix;
        // green counts twice
        return (plane == 2'd1) ? ext << 1 : ext;
    endfunction

    assign row_ready = !crop_valid;
    assign row_hs    = row_valid && row_ready;
    assign slot      = 3'(row_cnt % focus_pkg::crop_dim);
    assign last_row  = row_cnt == 5'(focus_pkg::num_planes * focus_pkg::crop_dim - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_cnt    <= '0;
            crop_valid <= 1'b0;
        end else if (row_hs) begin
            row_cnt <= last_row ? 5'd0 : row_cnt + 5'd1;
            if (last_row) begin
                crop_valid <= 1'b1;
            end
        end else if (crop_valid && crop_ready) begin
            crop_valid <= 1'b0;
        end
    end

    // first plane restarts each sum
    always_ff @(posedge clk) begin
        if (row_hs) begin
            for (int c = 0; c < focus_pkg::crop_dim; c++) begin
                if (row_plane == 2'd0) begin
                    sum_q[slot*focus_pkg::crop_dim + c] <=
                        weigh(row_pixels[c*focus_pkg::pix_w +: focus_pkg::pix_w], row_plane);
                end else begin
                    sum_q[slot*focus_pkg::crop_dim + c] <= sum_q[slot*focus_pkg::crop_dim + c]
                        + weigh(row_pixels[c*focus_pkg::pix_w +: focus_pkg::pix_w], row_plane);
                end
            end
        end
    end

    // grey value is the weighted sum over four
    always_comb begin
        for (int i = 0; i < focus_pkg::crop_dim * focus_pkg::crop_dim; i++) begin
            crop_gray[i*focus_pkg::pix_w +: focus_pkg::pix_w] = sum_q[i][focus_pkg::acc_w-1:2];
        end
    end

    // planes come in order, six rows each
    a_plane_order: assert property (@(posedge clk) disable iff (!rst_n)
        row_hs |-> row_plane == 2'(row_cnt / focus_pkg::crop_dim));

endmodule

// File: verilog/dram_reader.sv
module dram_reader (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_valid,
    input  logic [focus_pkg::pic_no_w-1:0]  in_pic_no,
    output logic [axi_read_pkg::addr_w-1:0] araddr,
    output logic                            arvalid,
    input  logic                            arready,
    input  logic [axi_read_pkg::data_w-1:0] rdata,
    input  logic                            rvalid,
    input  logic                            rlast,
    output logic                            rready,
    output logic                            row_valid,
    output focus_pkg::row_t                 row_pixels,
    output logic [1:0]                      row_plane,
    input  logic                            row_ready
);

    logic [focus_pkg::pic_no_w-1:0] pic_q;
    logic [1:0]                     plane_q;
    logic                           reading;
    logic [3:0]                     beat_cnt;
    logic                           last_beat;
    logic                           idle;
    logic                           ar_hs;
    logic                           r_hs;
    // crop columns held in the first beat of a row
    logic [(axi_read_pkg::beat_bytes-focus_pkg::crop_col0)*focus_pkg::pix_w-1:0] head_q;

    assign idle      = !arvalid && !reading;
    assign ar_hs     = arvalid && arready;
    assign r_hs      = rvalid && rready;
    assign last_beat = beat_cnt == 4'(axi_read_pkg::burst_len - 1);

    // stall the bus while a finished row waits
    assign rready = reading && (!row_valid || row_ready);

    assign araddr = axi_read_pkg::dram_base
                  + pic_q * axi_read_pkg::pic_stride
                  + plane_q * axi_read_pkg::plane_stride
                  + axi_read_pkg::crop_offset;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pic_q    <= '0;
            plane_q  <= '0;
            arvalid  <= 1'b0;
            reading  <= 1'b0;
            beat_cnt <= '0;
        end else if (in_valid && idle) begin
            pic_q   <= in_pic_no;
            plane_q <= '0;
            arvalid <= 1'b1;
        end else if (ar_hs) begin
            arvalid  <= 1'b0;
            reading  <= 1'b1;
            beat_cnt <= '0;
        end else if (r_hs) begin
            beat_cnt <= beat_cnt + 4'd1;
            if (last_beat) begin
                reading <= 1'b0;
                // next plane address right after the last beat
                if (plane_q != 2'(focus_pkg::num_planes - 1)) begin
                    plane_q <= plane_q + 2'd1;
                    arvalid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
        end else if (r_hs && beat_cnt[0]) begin
            row_valid <= 1'b1;
        end else if (row_ready) begin
            row_valid <= 1'b0;
        end
    end

    // even beat gives bytes 13..15, odd beat bytes 0..2
    always_ff @(posedge clk) begin
        if (r_hs && !beat_cnt[0]) begin
            head_q <= rdata[focus_pkg::crop_col0*focus_pkg::pix_w +: $bits(head_q)];
        end
        if (r_hs && beat_cnt[0]) begin
            row_pixels <= {rdata[0 +: $bits(focus_pkg::row_t) - $bits(head_q)], head_q};
            row_plane  <= plane_q;
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

    // slave must close every burst on beat 12
    a_rlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
        r_hs |-> (rlast == last_beat));

endmodule

// File: verilog/focus_pkg.sv
package focus_pkg;

    // ==================================================
    // pixels and crop geometry
    // ==================================================
    localparam int unsigned pix_w      = 8;
    // r + 2g + b before the divide by four
    localparam int unsigned acc_w      = 10;
    localparam int unsigned crop_dim   = 6;
    localparam int unsigned crop_col0  = 13;
    localparam int unsigned pic_no_w   = 4;
    localparam int unsigned num_planes = 3;

    // pixel 0 sits in the low byte
    typedef logic [crop_dim*pix_w-1:0] row_t;

    // pixel (r, c) at index r*crop_dim + c
    typedef logic [crop_dim*crop_dim*pix_w-1:0] crop_t;

    // ==================================================
    // focus result
    // ==================================================
    typedef enum logic [1:0] {
        win_2x2 = 2'd0,
        win_4x4 = 2'd1,
        win_6x6 = 2'd2
    } focus_t;

endpackage

// File: verilog/axi_read_pkg.sv
package axi_read_pkg;

    // ==================================================
    // AXI read channel
    // ==================================================
    localparam int unsigned addr_w     = 32;
    localparam int unsigned data_w     = 128;
    localparam int unsigned id_w       = 4;
    localparam int unsigned beat_bytes = 16;

    // beats per colour plane, arlen is this minus one
    localparam int unsigned burst_len  = 12;

    localparam logic [1:0] burst_incr  = 2'b01;
    localparam logic [2:0] size_16b    = 3'b100;

    // ==================================================
    // DRAM picture layout
    // ==================================================
    localparam logic [addr_w-1:0] dram_base = 32'h0001_0000;
    localparam int unsigned pic_stride      = 3072;
    localparam int unsigned plane_stride    = 1024;
    // row 13 of a 32 byte wide plane
    localparam int unsigned crop_offset     = 416;

endpackage
